/* list.f */
+incdir+design
design/mm_pkg.sv
design/mm_sequencer.sv
design/mm_operand_fetch.sv
design/mm_sum_stationary.sv
design/mm_output_writer.sv
design/mm_top.sv
bench/tb_clock_gen.sv
bench/tb_mm_memory.sv
bench/tb_mm_top.sv

/* Bender.yml */
package:
  name: mm_engine

sources:
  - include_dirs:
      - design
    files:
      - design/mm_pkg.sv
      - design/mm_sequencer.sv
      - design/mm_operand_fetch.sv
      - design/mm_sum_stationary.sv
      - design/mm_output_writer.sv
      - design/mm_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - bench/tb_clock_gen.sv
      - bench/tb_mm_memory.sv
      - bench/tb_mm_top.sv

/* bench/tb_mm_top.sv */
`timescale 1ns/1ps
`include "mm_cfg.svh"

module tb_mm_top;
  import mm_pkg::*;

  localparam int N_INSTR  = 5;
  localparam int ROW_BITS = $clog2(`MM_N);
  // Allow 150 cycles per row to cover the fetch and random write stalls
  localparam int TIMEOUT_CYCLES = N_INSTR * `MM_N * 150;
  // Instruction n waits with valid high while n-1 still runs when bit n is set
  localparam logic [N_INSTR-1:0] BACK_TO_BACK = 5'b01010;

  logic       clk;
  logic       rst_n;
  mm_instr_t  instr;
  logic       instr_valid;
  logic       instr_ready;
  logic       done;
  mm_rd_req_t a_rd;
  mm_rd_req_t b_rd;
  mm_in_row_t a_data;
  mm_in_row_t b_data;
  mm_wr_req_t c_wr;
  logic       c_wr_ready;
  logic       stall;
  int         wr_count;

  // Operands, bases and the reference product per instruction
  mm_instr_t   instrs [N_INSTR];
  mm_in_row_t  a_mat [N_INSTR][`MM_N];
  mm_in_row_t  b_mat [N_INSTR][`MM_N];
  mm_out_row_t exp_c [N_INSTR][`MM_N];

  logic [31:0] lfsr_q = 32'h7210;
  int          err_cnt = 0;
  int          cycle_cnt;

  // Instruction tracking
  logic             accept;
  logic             hs;
  logic             last_write;
  logic             busy_q;
  int               acc_cnt;
  int               cur_idx;
  logic [`MM_N-1:0] wr_mask_q;
  mm_addr_t         row_off;
  mm_out_row_t      exp_row;

  tb_clock_gen i_clock_gen (
    .clk_o  (clk),
    .rst_n_o(rst_n)
  );

  tb_mm_memory i_mem (
    .clk_i       (clk),
    .a_rd_i      (a_rd),
    .a_data_o    (a_data),
    .b_rd_i      (b_rd),
    .b_data_o    (b_data),
    .c_wr_i      (c_wr),
    .stall_i     (stall),
    .c_wr_ready_o(c_wr_ready),
    .wr_count_o  (wr_count)
  );

  mm_top i_mm_top (
    .clk_i        (clk),
    .rst_n_i      (rst_n),
    .instr_i      (instr),
    .instr_valid_i(instr_valid),
    .instr_ready_o(instr_ready),
    .done_o       (done),
    .a_rd_o       (a_rd),
    .a_data_i     (a_data),
    .b_rd_o       (b_rd),
    .b_data_i     (b_data),
    .c_wr_o       (c_wr),
    .c_wr_ready_i (c_wr_ready)
  );

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] rand_bits(input int width);
    logic [31:0] val;
    val = '0;
    for (int b = 0; b < width; b++) begin
      lfsr_q = lfsr_next(lfsr_q);
      val    = {val[30:0], lfsr_q[0]};
    end
    return val;
  endfunction

  // Random operands in disjoint A and B regions and the reference C = A x B
  task automatic build_tests();
    mm_acc_t acc;
    for (int n = 0; n < N_INSTR; n++) begin
      instrs[n].a_base = mm_addr_t'(16'h0100 * n + rand_bits(6));
      instrs[n].b_base = mm_addr_t'(16'h8000 + 16'h0100 * n + rand_bits(6));
      instrs[n].c_base = mm_addr_t'(rand_bits(16));
      for (int r = 0; r < `MM_N; r++) begin
        for (int e = 0; e < `MM_N; e++) begin
          a_mat[n][r][e] = mm_elem_t'(rand_bits(8));
          b_mat[n][r][e] = mm_elem_t'(rand_bits(8));
        end
        i_mem.write_row(instrs[n].a_base + mm_addr_t'(r), a_mat[n][r]);
        i_mem.write_row(instrs[n].b_base + mm_addr_t'(r), b_mat[n][r]);
      end
      for (int i = 0; i < `MM_N; i++) begin
        for (int j = 0; j < `MM_N; j++) begin
          acc = '0;
          for (int k = 0; k < `MM_N; k++) begin
            acc = acc + mm_acc_t'(a_mat[n][i][k]) * mm_acc_t'(b_mat[n][k][j]);
          end
          exp_c[n][i][j] = acc;
        end
      end
    end
  endtask

  task automatic report_counts();
    $display("Summary: %0d instructions accepted, %0d C rows written, %0d errors",
             acc_cnt, wr_count, err_cnt);
  endtask

  assign accept     = instr_valid && instr_ready;
  assign hs         = c_wr.valid && c_wr_ready;
  assign cur_idx    = (acc_cnt == 0) ? 0 : acc_cnt - 1;
  // Row of C relative to the running instruction
  assign row_off    = c_wr.addr - instrs[cur_idx].c_base;
  assign exp_row    = exp_c[cur_idx][row_off[ROW_BITS-1:0]];
  assign last_write = hs &&
    ((wr_mask_q | (`MM_N'(1) << row_off[ROW_BITS-1:0])) == {`MM_N{1'b1}});

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      acc_cnt   <= 0;
      wr_mask_q <= '0;
      busy_q    <= 1'b0;
    end else begin
      if (accept) begin
        acc_cnt   <= acc_cnt + 1;
        wr_mask_q <= '0;
      end else if (hs && row_off < `MM_N) begin
        wr_mask_q[row_off[ROW_BITS-1:0]] <= 1'b1;
      end
      // Busy from acceptance until done shows up
      if (accept) begin
        busy_q <= 1'b1;
      end else if (done) begin
        busy_q <= 1'b0;
      end
    end
  end

  // Idle outputs during reset and on the first edge after it
  a_reset_state: assert property (@(posedge clk) (!rst_n || $rose(rst_n)) |->
    (instr_ready && !done && !a_rd.req && !b_rd.req && !c_wr.valid))
    else begin
      err_cnt++;
      $display("ERROR %0t: outputs not idle around reset", $time);
    end

  a_wr_addr: assert property (@(posedge clk) disable iff (!rst_n)
    hs |-> row_off < `MM_N)
    else begin
      err_cnt++;
      $display("ERROR %0t: C write to %h is outside the C tile", $time, c_wr.addr);
    end

  a_wr_data: assert property (@(posedge clk) disable iff (!rst_n)
    hs |-> c_wr.data == exp_row)
    else begin
      err_cnt++;
      $display("ERROR %0t: C row %h is %h, expected %h", $time, c_wr.addr, c_wr.data,
               exp_row);
    end

  a_wr_once: assert property (@(posedge clk) disable iff (!rst_n)
    hs |-> !wr_mask_q[row_off[ROW_BITS-1:0]])
    else begin
      err_cnt++;
      $display("At %0t the C row %h was written a second time", $time, c_wr.addr);
    end

  // Stalled write holds address and data
  a_wr_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (c_wr.valid && !c_wr_ready) |=>
      (c_wr.valid && $stable(c_wr.addr) && $stable(c_wr.data)))
    else begin
      err_cnt++;
      $display("At %0t a stalled C write changed or dropped before acceptance", $time);
    end

  a_done_after_last: assert property (@(posedge clk) disable iff (!rst_n)
    last_write |=> done)
    else begin
      err_cnt++;
      $display("At %0t done did not rise one cycle after the fourth C write", $time);
    end

  a_done_rise: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(done) |-> ($past(hs) && wr_mask_q == {`MM_N{1'b1}}))
    else begin
      err_cnt++;
      $display("At %0t done rose before all four C rows were written", $time);
    end

  // Done held until the next instruction
  a_done_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (done && !accept) |=> done)
    else begin
      err_cnt++;
      $display("At %0t done fell without a new instruction", $time);
    end

  a_done_clear: assert property (@(posedge clk) disable iff (!rst_n)
    accept |=> !done)
    else begin
      err_cnt++;
      $display("At %0t a new instruction did not clear done", $time);
    end

  a_ready_low: assert property (@(posedge clk) disable iff (!rst_n)
    (busy_q && !done) |-> !instr_ready)
    else begin
      err_cnt++;
      $display("At %0t instr_ready was high while an instruction was running", $time);
    end

  // Random write back-pressure on about half the cycles
  always @(posedge clk) begin
    stall <= (rand_bits(1) != 0);
  end

  initial begin
    instr       = '0;
    instr_valid = 1'b0;
    stall       = 1'b0;
    build_tests();
    @(posedge rst_n);
    @(posedge clk);
    for (int n = 0; n < N_INSTR; n++) begin
      if (!BACK_TO_BACK[n]) begin
        repeat (2) @(posedge clk);
      end
      instr       <= instrs[n];
      instr_valid <= 1'b1;
      // Ready seen at the falling edge means acceptance at the next rise
      do begin
        @(negedge clk);
      end while (!instr_ready);
      @(posedge clk);
      if (n == N_INSTR - 1 || !BACK_TO_BACK[n+1]) begin
        instr_valid <= 1'b0;
        do begin
          @(negedge clk);
        end while (!done);
        @(posedge clk);
      end
    end
    repeat (2) @(posedge clk);
    if (wr_count != N_INSTR * `MM_N) begin
      err_cnt++;
      $display("ERROR %0t: %0d C writes in total, expected %0d", $time, wr_count,
               N_INSTR * `MM_N);
    end
    report_counts();
    if (err_cnt == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // Run limit
  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    report_counts();
    $display("Test failed");
    $finish;
  end

endmodule

/* bench/tb_mm_memory.sv */
`timescale 1ns/1ps
`include "mm_cfg.svh"

module tb_mm_memory (
  input  logic               clk_i,
  input  mm_pkg::mm_rd_req_t a_rd_i,
  output mm_pkg::mm_in_row_t a_data_o,
  input  mm_pkg::mm_rd_req_t b_rd_i,
  output mm_pkg::mm_in_row_t b_data_o,
  input  mm_pkg::mm_wr_req_t c_wr_i,
  input  logic               stall_i,
  output logic               c_wr_ready_o,
  output int                 wr_count_o
);
  import mm_pkg::*;

  // A and B rows share one word array
  mm_in_row_t  mem [0:(1 << `MM_ADDR_W)-1];

  // Random stall bit comes from the testbench LFSR
  assign c_wr_ready_o = !stall_i;

  initial begin
    a_data_o   = '0;
    b_data_o   = '0;
    wr_count_o = 0;
  end

  // One-cycle read latency on both ports
  always @(posedge clk_i) begin
    if (a_rd_i.req) begin
      a_data_o <= mem[a_rd_i.addr];
    end
    if (b_rd_i.req) begin
      b_data_o <= mem[b_rd_i.addr];
    end
  end

  // Count each completed handshake
  always @(posedge clk_i) begin
    if (c_wr_i.valid && c_wr_ready_o) begin
      wr_count_o <= wr_count_o + 1;
    end
  end

  // Loader used before the run starts
  task automatic write_row(input mm_addr_t addr, input mm_in_row_t row);
    mem[addr] = row;
  endtask

endmodule

/* bench/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk_o,
  output logic rst_n_o
);

  // 20 ns period
  initial begin
    clk_o = 1'b0;
    forever begin
      #10 clk_o = ~clk_o;
    end
  end

  // Reset falls just after time zero, held over two rising edges
  initial begin
    rst_n_o = 1'b1;
    #2;
    rst_n_o = 1'b0;
    repeat (2) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

/* design/mm_top.sv */
`timescale 1ns/1ps

module mm_top (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  mm_pkg::mm_instr_t  instr_i,
  input  logic               instr_valid_i,
  output logic               instr_ready_o,
  output logic               done_o,
  output mm_pkg::mm_rd_req_t a_rd_o,
  input  mm_pkg::mm_in_row_t a_data_i,
  output mm_pkg::mm_rd_req_t b_rd_o,
  input  mm_pkg::mm_in_row_t b_data_i,
  output mm_pkg::mm_wr_req_t c_wr_o,
  input  logic               c_wr_ready_i
);
  import mm_pkg::*;

  // Sequencer to fetch
  mm_job_t    job;
  logic       job_valid;
  logic       fetch_idle;
  // Fetch to processor
  mm_step_t   step;
  logic       step_valid;
  logic       mac_ready;
  // Processor to writer
  mm_result_t result;
  logic       result_valid;
  logic       writer_free;
  // Writer back to sequencer
  logic       row_written;

  mm_sequencer i_mm_sequencer (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .instr_i      (instr_i),
    .instr_valid_i(instr_valid_i),
    .instr_ready_o(instr_ready_o),
    .done_o       (done_o),
    .fetch_idle_i (fetch_idle),
    .job_o        (job),
    .job_valid_o  (job_valid),
    .row_written_i(row_written)
  );

  mm_operand_fetch i_mm_operand_fetch (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .job_i       (job),
    .job_valid_i (job_valid),
    .fetch_idle_o(fetch_idle),
    .mac_ready_i (mac_ready),
    .a_rd_o      (a_rd_o),
    .a_data_i    (a_data_i),
    .b_rd_o      (b_rd_o),
    .b_data_i    (b_data_i),
    .step_o      (step),
    .step_valid_o(step_valid)
  );

  mm_sum_stationary i_mm_sum_stationary (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .step_i        (step),
    .step_valid_i  (step_valid),
    .mac_ready_o   (mac_ready),
    .writer_free_i (writer_free),
    .result_o      (result),
    .result_valid_o(result_valid)
  );

  mm_output_writer i_mm_output_writer (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .result_i      (result),
    .result_valid_i(result_valid),
    .writer_free_o (writer_free),
    .c_wr_o        (c_wr_o),
    .c_wr_ready_i  (c_wr_ready_i),
    .row_written_o (row_written)
  );

endmodule

/* design/mm_output_writer.sv */
`timescale 1ns/1ps

module mm_output_writer (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  mm_pkg::mm_result_t result_i,
  input  logic               result_valid_i,
  output logic               writer_free_o,
  output mm_pkg::mm_wr_req_t c_wr_o,
  input  logic               c_wr_ready_i,
  output logic               row_written_o
);
  import mm_pkg::*;

  mm_result_t buf_q;
  logic       valid_q;

  // Free again the cycle after the handshake
  assign writer_free_o = !valid_q;
  assign row_written_o = valid_q && c_wr_ready_i;

  assign c_wr_o = '{valid: valid_q, addr: buf_q.c_addr, data: buf_q.row};

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (result_valid_i) begin
      valid_q <= 1'b1;
    end else if (row_written_o) begin
      valid_q <= 1'b0;
    end
  end

  // Only loaded while empty, so held under back-pressure
  always_ff @(posedge clk_i) begin
    if (result_valid_i) begin
      buf_q <= result_i;
    end
  end

  // Stalled write keeps its address and data until accepted
  a_wr_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (c_wr_o.valid && !c_wr_ready_i) |=>
      c_wr_o.valid && $stable(c_wr_o.addr) && $stable(c_wr_o.data));

endmodule

/* design/mm_sum_stationary.sv */
`timescale 1ns/1ps
`include "mm_cfg.svh"

module mm_sum_stationary (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  mm_pkg::mm_step_t   step_i,
  input  logic               step_valid_i,
  output logic               mac_ready_o,
  input  logic               writer_free_i,
  output mm_pkg::mm_result_t result_o,
  output logic               result_valid_o
);
  import mm_pkg::*;

  mm_out_row_t sum_q;
  mm_out_row_t sum_d;
  mm_result_t  res_q;
  // Next step opens a new row
  logic        first_q;
  // Result register full
  logic        held_q;

  // Four lanes, each against its own B column
  always_comb begin
    logic [2*`MM_DATA_W-1:0] prod;
    mm_acc_t                 base;
    for (int j = 0; j < `MM_N; j++) begin
      prod     = step_i.a_elem * step_i.b_row[j];
      base     = first_q ? '0 : sum_q[j];
      sum_d[j] = base + mm_acc_t'(prod);
    end
  end

  // Register frees in the same cycle the writer takes it
  assign result_valid_o = held_q && writer_free_i;
  assign mac_ready_o    = !held_q || writer_free_i;
  assign result_o       = res_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      first_q <= 1'b1;
      held_q  <= 1'b0;
    end else begin
      if (step_valid_i) begin
        first_q <= step_i.last;
      end
      if (result_valid_o) begin
        held_q <= 1'b0;
      end
      if (step_valid_i && step_i.last) begin
        held_q <= 1'b1;
      end
    end
  end

  // Sums stay in place, the finished row is frozen on the last step
  always_ff @(posedge clk_i) begin
    if (step_valid_i) begin
      sum_q <= sum_d;
    end
    if (step_valid_i && step_i.last) begin
      res_q.row    <= sum_d;
      res_q.c_addr <= step_i.c_addr;
    end
  end

  // Fetch gating must keep a finished row from being overwritten
  a_no_overwrite: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (step_valid_i && step_i.last) |-> (!held_q || writer_free_i));

endmodule

/* design/mm_operand_fetch.sv */
`timescale 1ns/1ps
`include "mm_cfg.svh"

module mm_operand_fetch (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  mm_pkg::mm_job_t    job_i,
  input  logic               job_valid_i,
  output logic               fetch_idle_o,
  input  logic               mac_ready_i,
  output mm_pkg::mm_rd_req_t a_rd_o,
  input  mm_pkg::mm_in_row_t a_data_i,
  output mm_pkg::mm_rd_req_t b_rd_o,
  input  mm_pkg::mm_in_row_t b_data_i,
  output mm_pkg::mm_step_t   step_o,
  output logic               step_valid_o
);
  import mm_pkg::*;

  fetch_state_e             state_q;
  mm_job_t                  job_q;
  mm_in_row_t               a_row_q;
  logic [$clog2(`MM_N)-1:0] b_cnt_q;
  logic [$clog2(`MM_N)-1:0] step_idx_q;
  // Read data arrives this cycle
  logic                     a_pend_q;
  logic                     b_pend_q;

  // Still busy while the last B row is on its way back
  assign fetch_idle_o = (state_q == FETCH_IDLE) && !b_pend_q;

  assign a_rd_o = '{req: state_q == FETCH_READ_A, addr: job_q.a_addr};
  assign b_rd_o = '{
    req:  state_q == FETCH_READ_B,
    addr: job_q.b_base + mm_addr_t'(b_cnt_q)
  };

  // B row k straight from memory paired with A[i][k]
  assign step_valid_o = b_pend_q;
  assign step_o = '{
    a_elem: a_row_q[step_idx_q],
    b_row:  b_data_i,
    last:   step_idx_q == `MM_N-1,
    c_addr: job_q.c_addr
  };

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q    <= FETCH_IDLE;
      b_cnt_q    <= '0;
      step_idx_q <= '0;
      a_pend_q   <= 1'b0;
      b_pend_q   <= 1'b0;
    end else begin
      // One-cycle memory latency
      a_pend_q   <= (state_q == FETCH_READ_A);
      b_pend_q   <= (state_q == FETCH_READ_B);
      step_idx_q <= b_cnt_q;
      case (state_q)
        FETCH_IDLE: begin
          if (job_valid_i) begin
            state_q <= mac_ready_i ? FETCH_READ_A : FETCH_WAIT;
          end
        end
        // Processor still holds a row nobody took
        FETCH_WAIT: begin
          if (mac_ready_i) begin
            state_q <= FETCH_READ_A;
          end
        end
        FETCH_READ_A: begin
          state_q <= FETCH_READ_B;
          b_cnt_q <= '0;
        end
        FETCH_READ_B: begin
          b_cnt_q <= b_cnt_q + 1'b1;
          if (b_cnt_q == `MM_N-1) begin
            state_q <= FETCH_IDLE;
          end
        end
        default: state_q <= FETCH_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (job_valid_i && state_q == FETCH_IDLE) begin
      job_q <= job_i;
    end
    if (a_pend_q) begin
      a_row_q <= a_data_i;
    end
  end

  // Job from the sequencer never meets a read in flight
  a_no_req_on_job: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    job_valid_i |-> fetch_idle_o && !a_rd_o.req && !b_rd_o.req);

endmodule

/* design/mm_sequencer.sv */
`timescale 1ns/1ps
`include "mm_cfg.svh"

module mm_sequencer (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  mm_pkg::mm_instr_t instr_i,
  input  logic              instr_valid_i,
  output logic              instr_ready_o,
  output logic              done_o,
  input  logic              fetch_idle_i,
  output mm_pkg::mm_job_t   job_o,
  output logic              job_valid_o,
  input  logic              row_written_i
);
  import mm_pkg::*;

  typedef logic [$clog2(`MM_N)-1:0] row_cnt_t;
  typedef logic [$clog2(`MM_N+1)-1:0] pend_cnt_t;

  seq_state_e state_q;
  mm_instr_t  base_q;
  row_cnt_t   row_q;
  pend_cnt_t  pending_q;
  logic       done_q;

  // Only take a new instruction once the previous one is fully written
  assign instr_ready_o = (state_q == SEQ_IDLE);
  assign done_o        = done_q;

  // Job goes out the same cycle the fetch reports idle
  assign job_valid_o = (state_q == SEQ_ISSUE) && fetch_idle_i;
  assign job_o = '{
    a_addr: base_q.a_base + mm_addr_t'(row_q),
    b_base: base_q.b_base,
    c_addr: base_q.c_base + mm_addr_t'(row_q)
  };

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q   <= SEQ_IDLE;
      row_q     <= '0;
      pending_q <= '0;
      done_q    <= 1'b0;
    end else begin
      // Writes may land while later rows are still being issued
      if (row_written_i) begin
        pending_q <= pending_q - 1'b1;
      end
      case (state_q)
        SEQ_IDLE: begin
          if (instr_valid_i) begin
            state_q   <= SEQ_ISSUE;
            row_q     <= '0;
            pending_q <= pend_cnt_t'(`MM_N);
            done_q    <= 1'b0;
          end
        end
        SEQ_ISSUE: begin
          if (fetch_idle_i) begin
            row_q <= row_q + 1'b1;
            if (row_q == `MM_N-1) begin
              state_q <= SEQ_DRAIN;
            end
          end
        end
        SEQ_DRAIN: begin
          // Last outstanding write completes here
          if (row_written_i && pending_q == 1) begin
            done_q  <= 1'b1;
            state_q <= SEQ_IDLE;
          end
        end
        default: state_q <= SEQ_IDLE;
      endcase
    end
  end

  // Bases held for the whole instruction
  always_ff @(posedge clk_i) begin
    if (instr_valid_i && instr_ready_o) begin
      base_q <= instr_i;
    end
  end

  // Fetch leaves idle right after taking a job so no second job lands on it
  a_job_to_idle_fetch: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    job_valid_o |=> !fetch_idle_i);

endmodule

/* design/mm_pkg.sv */
`include "mm_cfg.svh"

package mm_pkg;

  typedef logic [`MM_DATA_W-1:0] mm_elem_t;
  typedef logic [`MM_ACC_W-1:0] mm_acc_t;
  typedef logic [`MM_ADDR_W-1:0] mm_addr_t;

  // One A/B memory word, lane 0 in the low bits
  typedef mm_elem_t [`MM_N-1:0] mm_in_row_t;
  // One C memory word
  typedef mm_acc_t [`MM_N-1:0] mm_out_row_t;

  typedef struct packed {
    mm_addr_t a_base;
    mm_addr_t b_base;
    mm_addr_t c_base;
  } mm_instr_t;

  // Work for one row of C
  typedef struct packed {
    mm_addr_t a_addr;
    mm_addr_t b_base;
    mm_addr_t c_addr;
  } mm_job_t;

  // A[i][k] paired with B row k
  typedef struct packed {
    mm_elem_t   a_elem;
    mm_in_row_t b_row;
    logic       last;
    mm_addr_t   c_addr;
  } mm_step_t;

  typedef struct packed {
    mm_out_row_t row;
    mm_addr_t    c_addr;
  } mm_result_t;

  typedef struct packed {
    logic     req;
    mm_addr_t addr;
  } mm_rd_req_t;

  typedef struct packed {
    logic        valid;
    mm_addr_t    addr;
    mm_out_row_t data;
  } mm_wr_req_t;

  typedef enum logic [1:0] {
    SEQ_IDLE,
    SEQ_ISSUE,
    SEQ_DRAIN
  } seq_state_e;

  typedef enum logic [1:0] {
    FETCH_IDLE,
    FETCH_READ_A,
    FETCH_READ_B,
    FETCH_WAIT
  } fetch_state_e;

endpackage

/* design/mm_cfg.svh */
`ifndef MM_CFG_SVH
`define MM_CFG_SVH

// Tile size, also the lane count
`define MM_N 4

// Unsigned element width
`define MM_DATA_W 8

// 16-bit product plus 16 bits of accumulation headroom
`define MM_ACC_W 32

// Word address, one matrix row per word
`define MM_ADDR_W 16

`endif
